//--- src/sdhcal_defines.svh
`ifndef SDHCAL_DEFINES_SVH
`define SDHCAL_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////
`define SDH_WORD_W      16  // control word and result word
`define SDH_DAC_W       10  // discriminator threshold code
`define SDH_CHN_W       6   // test channel number
`define SDH_NCHN        64  // channels per asic
`define SDH_WIN_W       12  // counting window length

// dac0 + dac1 + dac2 + ctest mask
`define SDH_FRAME_LEN   94
`define SDH_FIFO_DEPTH  16

////////////////////////////////////////////////////////////////////////////
// opcodes, top nibble of the control word
////////////////////////////////////////////////////////////////////////////
`define SDH_OP_SET_DAC  4'd1
`define SDH_OP_SET_CHN  4'd2
`define SDH_OP_SET_WIN  4'd3
`define SDH_OP_LOAD     4'd4
`define SDH_OP_SCURVE   4'd5

`endif

//--- src/sdhcal_pkg.sv
`default_nettype none

`include "sdhcal_defines.svh"

package sdhcal_pkg;

    typedef enum logic [3:0] {
        OP_SET_DAC = `SDH_OP_SET_DAC,
        OP_SET_CHN = `SDH_OP_SET_CHN,
        OP_SET_WIN = `SDH_OP_SET_WIN,
        OP_LOAD    = `SDH_OP_LOAD,
        OP_SCURVE  = `SDH_OP_SCURVE
    } opcode_t;

    typedef logic [`SDH_DAC_W-1:0]  dac_t;    // threshold code
    typedef logic [`SDH_WORD_W-1:0] count_t;  // saturating trigger count

    // command view: opcode + 12-bit argument
    typedef struct packed {
        opcode_t     op;
        logic [11:0] arg;
    } cmd_view_t;

    // parameter view: opcode, which dac, dac value
    typedef struct packed {
        opcode_t    op;
        logic [1:0] sel;
        dac_t       val;
    } param_view_t;

    // one 16-bit word, read either way
    typedef union packed {
        cmd_view_t   cmd;
        param_view_t par;
    } ctrl_word_u;

endpackage

`default_nettype wire

//--- src/usb_cmd_decoder.sv
`default_nettype none

`include "sdhcal_defines.svh"

module usb_cmd_decoder import sdhcal_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cmd_valid,
    input  ctrl_word_u            cmd_word,
    output dac_t                  dac0,
    output dac_t                  dac1,
    output dac_t                  dac2,
    output logic [`SDH_CHN_W-1:0] test_chn,
    output logic [`SDH_WIN_W-1:0] win_len,
    output logic                  load_cmd,     // one cycle
    output logic                  scurve_start, // one cycle
    output dac_t                  end_code
);

    ////////////////////////////////////////////////////////////////////////////
    // parameter registers and command pulses
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            dac0         <= '0;
            dac1         <= '0;
            dac2         <= '0;
            test_chn     <= '0;
            win_len      <= `SDH_WIN_W'd100;  // default window
            load_cmd     <= 1'b0;
            scurve_start <= 1'b0;
            end_code     <= '0;
        end else begin
            // pulses last one cycle only
            load_cmd     <= 1'b0;
            scurve_start <= 1'b0;
            if (cmd_valid) begin
                case (cmd_word.cmd.op)
                    OP_SET_DAC: begin
                        // parameter view picks the threshold
                        case (cmd_word.par.sel)
                            2'd0:    dac0 <= cmd_word.par.val;
                            2'd1:    dac1 <= cmd_word.par.val;
                            2'd2:    dac2 <= cmd_word.par.val;
                            default: ;  // sel 3 unused
                        endcase
                    end
                    OP_SET_CHN: test_chn <= cmd_word.cmd.arg[`SDH_CHN_W-1:0];
                    OP_SET_WIN: win_len  <= cmd_word.cmd.arg;
                    OP_LOAD:    load_cmd <= 1'b1;
                    OP_SCURVE: begin
                        scurve_start <= 1'b1;
                        end_code     <= cmd_word.cmd.arg[`SDH_DAC_W-1:0];  // last code
                    end
                    default: ;  // unknown opcode, dropped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sc_serializer.sv
`default_nettype none

`include "sdhcal_defines.svh"

module sc_serializer import sdhcal_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load_req,
    input  dac_t                 frame_dac0,
    input  dac_t                 frame_dac1,
    input  dac_t                 frame_dac2,
    input  wire [`SDH_CHN_W-1:0] frame_chn,
    output logic                 load_ack,
    output logic                 select,
    output logic                 sr_rstb,
    output logic                 sr_ck,
    output logic                 sr_in
);

    localparam int frame_len = `SDH_FRAME_LEN;
    localparam int cnt_w     = $clog2(frame_len);

    typedef enum logic [1:0] {S_IDLE, S_RST, S_SHIFT, S_ACK} state_t;

    state_t                 state;
    logic [frame_len-1:0]   shreg;    // frame, msb goes out first
    logic [cnt_w-1:0]       bit_cnt;
    logic                   phase;    // 0 = data setup, 1 = sr_ck high
    logic [`SDH_NCHN-1:0]   ctest;

    // test capacitor on the selected channel only
    assign ctest = {{(`SDH_NCHN-1){1'b0}}, 1'b1} << frame_chn;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            phase    <= 1'b0;
            load_ack <= 1'b0;
            select   <= 1'b0;
            sr_rstb  <= 1'b1;
            sr_ck    <= 1'b0;
            sr_in    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (load_req && !load_ack) begin
                    select  <= 1'b1;
                    sr_rstb <= 1'b0;  // one-cycle register reset
                    state   <= S_RST;
                end
                S_RST: begin
                    sr_rstb <= 1'b1;
                    sr_in   <= shreg[frame_len-1];  // first bit, clock low
                    bit_cnt <= '0;
                    phase   <= 1'b0;
                    state   <= S_SHIFT;
                end
                S_SHIFT: begin
                    phase <= ~phase;
                    sr_ck <= ~phase;  // high on second half of each bit
                    if (phase) begin
                        if (bit_cnt == cnt_w'(frame_len - 1)) begin
                            load_ack <= 1'b1;  // last bit clocked
                            select   <= 1'b0;
                            state    <= S_ACK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sr_in   <= shreg[frame_len-2];
                        end
                    end
                end
                S_ACK: if (!load_req) begin
                    load_ack <= 1'b0;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // frame shift register, no reset
    always_ff @(posedge clk) begin
        if (state == S_IDLE && load_req && !load_ack) begin
            shreg <= {frame_dac0, frame_dac1, frame_dac2, ctest};
        end else if (state == S_SHIFT && phase) begin
            shreg <= {shreg[frame_len-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- src/trigger_counter.sv
`default_nettype none

`include "sdhcal_defines.svh"

module trigger_counter import sdhcal_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  out_trigb,  // async, active low
    input  wire [`SDH_WIN_W-1:0] win_len,
    input  wire                  win_start,
    output logic                 win_done,
    output count_t               count
);

    logic                  trig_s1, trig_s2, trig_d;  // sync pair + edge delay
    logic                  trig_fall;
    logic                  busy;
    logic [`SDH_WIN_W-1:0] win_cnt;                   // cycles left in window

    assign trig_fall = trig_d & ~trig_s2;

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_s1  <= 1'b1;  // idle high
            trig_s2  <= 1'b1;
            trig_d   <= 1'b1;
            busy     <= 1'b0;
            win_cnt  <= '0;
            win_done <= 1'b0;
            count    <= '0;
        end else begin
            trig_s1  <= out_trigb;
            trig_s2  <= trig_s1;
            trig_d   <= trig_s2;
            win_done <= 1'b0;
            if (win_start) begin
                busy    <= 1'b1;
                win_cnt <= win_len;
                count   <= '0;
            end else if (busy) begin
                if (trig_fall && count != '1) begin
                    count <= count + 1'b1;  // saturates at all ones
                end
                win_cnt <= win_cnt - 1'b1;
                if (win_cnt <= `SDH_WIN_W'd1) begin  // last window cycle
                    busy     <= 1'b0;
                    win_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/result_fifo.sv
`default_nettype none

`include "sdhcal_defines.svh"

module result_fifo import sdhcal_pkg::*; #(
    parameter int depth = `SDH_FIFO_DEPTH
) (
    input  wire    clk,
    input  wire    rst,
    input  wire    push,
    input  count_t din,
    output logic   full,
    input  wire    rd_en,
    output count_t dout,
    output logic   empty
);

    localparam int addr_w = $clog2(depth);
    localparam int cnt_w  = $clog2(depth + 1);

    count_t            mem [depth];
    logic [addr_w-1:0] wr_ptr, rd_ptr;
    logic [cnt_w-1:0]  occ;     // words stored
    logic              wr, rd;

    assign full  = (occ == cnt_w'(depth));
    assign empty = (occ == '0);
    assign wr    = push && !full;
    assign rd    = rd_en && !empty;
    assign dout  = mem[rd_ptr];  // fall-through head word

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (wr) wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd) rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) mem[wr_ptr] <= din;
    end

endmodule

`default_nettype wire

//--- src/scurve_sequencer.sv
`default_nettype none

`include "sdhcal_defines.svh"

module scurve_sequencer import sdhcal_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  dac_t                  dac0,
    input  dac_t                  dac1,
    input  dac_t                  dac2,
    input  wire [`SDH_CHN_W-1:0]  test_chn,
    input  wire                   load_cmd,
    input  wire                   scurve_start,
    input  dac_t                  end_code,
    output logic                  load_req,
    input  wire                   load_ack,
    output dac_t                  frame_dac0,
    output dac_t                  frame_dac1,
    output dac_t                  frame_dac2,
    output logic [`SDH_CHN_W-1:0] frame_chn,
    output logic                  win_start,
    input  wire                   win_done,
    input  count_t                count,
    output logic                  push,
    output count_t                push_data,
    input  wire                   full,
    output logic                  scurve_done
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_MAN_LOAD, ST_SW_LOAD, ST_COUNT, ST_PUSH, ST_DONE
    } state_t;

    state_t                state;
    dac_t                  code;      // current sweep threshold
    dac_t                  last_code; // end_code taken at start
    logic [`SDH_CHN_W-1:0] sw_chn;    // channel frozen for the sweep
    logic                  sweeping;

    ////////////////////////////////////////////////////////////////////////////
    // frame source select, user settings or sweep code
    ////////////////////////////////////////////////////////////////////////////
    assign sweeping   = (state == ST_SW_LOAD) || (state == ST_COUNT) || (state == ST_PUSH);
    assign frame_dac0 = sweeping ? code : dac0;
    assign frame_dac1 = sweeping ? code : dac1;
    assign frame_dac2 = sweeping ? code : dac2;
    assign frame_chn  = sweeping ? sw_chn : test_chn;

    assign push      = (state == ST_PUSH) && !full;  // hold off under back-pressure
    assign push_data = count;                        // held by counter until next window

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            load_req    <= 1'b0;
            win_start   <= 1'b0;
            scurve_done <= 1'b0;
            code        <= '0;
            last_code   <= '0;
            sw_chn      <= '0;
        end else begin
            win_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (scurve_start) begin
                        code        <= '0;
                        last_code   <= end_code;
                        sw_chn      <= test_chn;
                        scurve_done <= 1'b0;
                        load_req    <= 1'b1;
                        state       <= ST_SW_LOAD;
                    end else if (load_cmd) begin
                        load_req <= 1'b1;
                        state    <= ST_MAN_LOAD;
                    end
                end
                ST_MAN_LOAD: begin
                    if (load_req && load_ack) begin
                        load_req <= 1'b0;
                    end else if (!load_req && !load_ack) begin
                        state <= ST_IDLE;  // handshake closed
                    end
                end
                ST_SW_LOAD: begin
                    if (load_req && load_ack) begin
                        load_req <= 1'b0;
                    end else if (!load_req && !load_ack) begin
                        win_start <= 1'b1;  // open counting window
                        state     <= ST_COUNT;
                    end
                end
                ST_COUNT: if (win_done) state <= ST_PUSH;
                ST_PUSH: if (!full) begin
                    if (code == last_code) begin
                        state <= ST_DONE;
                    end else begin
                        code     <= code + 1'b1;  // next threshold
                        load_req <= 1'b1;
                        state    <= ST_SW_LOAD;
                    end
                end
                ST_DONE: begin
                    scurve_done <= 1'b1;  // held until next start
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/sdhcal_top.sv
`default_nettype none

`include "sdhcal_defines.svh"

module sdhcal_top import sdhcal_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        cmd_valid,
    input  ctrl_word_u cmd_word,
    input  wire        out_trigb,   // asic trigger, active low
    output logic       select,      // slow-control register select
    output logic       sr_rstb,
    output logic       sr_ck,
    output logic       sr_in,
    input  wire        fifo_rd_en,
    output count_t     fifo_dout,
    output logic       fifo_empty,
    output logic       scurve_done
);

    // decoder outputs
    dac_t                  dac0, dac1, dac2, end_code;
    logic [`SDH_CHN_W-1:0] test_chn;
    logic [`SDH_WIN_W-1:0] win_len;
    logic                  load_cmd, scurve_start;
    // serializer handshake
    logic                  load_req, load_ack;
    dac_t                  frame_dac0, frame_dac1, frame_dac2;
    logic [`SDH_CHN_W-1:0] frame_chn;
    // counter and fifo
    logic                  win_start, win_done, push, full;
    count_t                count, push_data;

    usb_cmd_decoder i_decoder (
        .clk, .rst, .cmd_valid, .cmd_word,
        .dac0, .dac1, .dac2, .test_chn, .win_len,
        .load_cmd, .scurve_start, .end_code
    );

    scurve_sequencer i_sequencer (
        .clk, .rst, .dac0, .dac1, .dac2, .test_chn,
        .load_cmd, .scurve_start, .end_code,
        .load_req, .load_ack,
        .frame_dac0, .frame_dac1, .frame_dac2, .frame_chn,
        .win_start, .win_done, .count,
        .push, .push_data, .full, .scurve_done
    );

    sc_serializer i_serializer (
        .clk, .rst, .load_req,
        .frame_dac0, .frame_dac1, .frame_dac2, .frame_chn,
        .load_ack, .select, .sr_rstb, .sr_ck, .sr_in
    );

    trigger_counter i_trig_cnt (
        .clk, .rst, .out_trigb, .win_len, .win_start, .win_done, .count
    );

    result_fifo #(.depth(`SDH_FIFO_DEPTH)) i_result_fifo (
        .clk, .rst, .push, .din(push_data), .full,
        .rd_en(fifo_rd_en), .dout(fifo_dout), .empty(fifo_empty)
    );

endmodule

`default_nettype wire

//--- dv/sdhcal_props.sv
`default_nettype none

module sdhcal_props (
    input wire clk,
    input wire rst,
    input wire select,
    input wire sr_ck,
    input wire push,
    input wire full,
    input wire fifo_rd_en,
    input wire fifo_empty
);

    ////////////////////////////////////////////////////////////////////////////
    // slow-control port
    ////////////////////////////////////////////////////////////////////////////
    a_sck_in_select: assert property (@(posedge clk) disable iff (rst)
        sr_ck |-> select)
        else $error("sr_ck high outside the select window");

    ////////////////////////////////////////////////////////////////////////////
    // result FIFO
    ////////////////////////////////////////////////////////////////////////////
    // full FIFO keeps every word until the host reads one
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (full && !fifo_rd_en) |=> full)
        else $error("full FIFO took a push or lost a word");

    // a read on empty must not underflow the occupancy
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        (fifo_empty && fifo_rd_en && !push) |=> fifo_empty)
        else $error("FIFO read while empty");

endmodule

bind sdhcal_top sdhcal_props i_props (
    .clk, .rst, .select, .sr_ck, .push, .full, .fifo_rd_en, .fifo_empty
);

`default_nettype wire

//--- dv/tb_sdhcal.sv
`default_nettype none

`include "sdhcal_defines.svh"

module tb_sdhcal import sdhcal_pkg::*; ();

    localparam int frame_len   = `SDH_FRAME_LEN;
    localparam int dac_w       = `SDH_DAC_W;
    localparam int win_cycles  = 60;                                   // sweep window
    localparam int step_cycles = 2 * frame_len + 10 + win_cycles + 10; // load, window, push
    localparam int wd_cycles   = (2 + 8 + 21 + 6) * step_cycles;       // all loads + slack

    typedef logic [frame_len-1:0] frame_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cmd_valid;
    ctrl_word_u            cmd_word;
    logic                  trigb;                // asic trigger, active low
    logic                  select, sr_rstb, sr_ck, sr_in;
    logic                  fifo_rd_en;
    count_t                fifo_dout;
    logic                  fifo_empty, scurve_done;

    integer                seed;
    logic [31:0]           rnd;
    dac_t                  d0, d1, d2;           // thresholds as last written
    logic [`SDH_CHN_W-1:0] chn;
    logic                  sweep_on;             // arms the trigger model
    frame_t                frames[$];            // rebuilt frames, oldest first
    dac_t                  trig_jobs[$];         // sweep codes still owed pulses
    frame_t                mon_frame;
    int                    mon_bits;

    always #5 clk = ~clk;

    sdhcal_top i_dut (
        .clk, .rst, .cmd_valid, .cmd_word, .out_trigb(trigb),
        .select, .sr_rstb, .sr_ck, .sr_in,
        .fifo_rd_en, .fifo_dout, .fifo_empty, .scurve_done
    );

    ////////////////////////////////////////////////////////////////////////////
    // serial monitor and trigger model
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin : serial_monitor
        if (rst) begin
            mon_bits = 0;
        end else if (select && sr_ck) begin                // one sample per sr_ck pulse
            mon_frame = {mon_frame[frame_len-2:0], sr_in}; // msb arrives first
            mon_bits++;
            if (mon_bits == frame_len) begin
                frames.push_back(mon_frame);
                if (sweep_on) trig_jobs.push_back(mon_frame[frame_len-1 -: dac_w]);
                mon_bits = 0;
            end
        end
    end

    initial begin : trigger_model
        int npulse;
        trigb = 1'b1;
        forever begin
            @(posedge clk);
            if (trig_jobs.size() != 0) begin
                npulse = int'(trig_jobs.pop_front()) % 5;
                repeat (10) @(posedge clk);   // window is open by now
                repeat (npulse) begin
                    trigb <= 1'b0;
                    repeat (2) @(posedge clk);
                    trigb <= 1'b1;
                    repeat (3) @(posedge clk);  // gap between pulses
                end
            end
        end
    end

    initial begin : watchdog
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", wd_cycles);
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_dac(input string name, input dac_t got, input dac_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_frame(input string name, input frame_t got, input frame_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // dac0, dac1, dac2, then ctest mask ch63 down to ch0
    function automatic frame_t frame_of(input dac_t a, input dac_t b, input dac_t c,
                                        input logic [`SDH_CHN_W-1:0] ch);
        logic [`SDH_NCHN-1:0] mask;
        mask     = '0;
        mask[ch] = 1'b1;
        return {a, b, c, mask};
    endfunction

    function automatic ctrl_word_u cmd_of(input opcode_t op, input logic [11:0] arg);
        ctrl_word_u w;
        w.cmd.op  = op;
        w.cmd.arg = arg;
        return w;
    endfunction

    function automatic ctrl_word_u dac_write_of(input logic [1:0] sel, input dac_t val);
        ctrl_word_u w;
        w.par.op  = OP_SET_DAC;
        w.par.sel = sel;
        w.par.val = val;
        return w;
    endfunction

    task automatic send_cmd(input ctrl_word_u w);
        cmd_word  <= w;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_frames(input int n, input int limit);
        int cyc;
        cyc = 0;
        while (frames.size() < n) begin
            if (cyc == limit) begin
                $display("only %0d of %0d frames seen in %0d cycles", frames.size(), n, limit);
                abort_run();
            end
            @(posedge clk);
            cyc++;
        end
    endtask

    task automatic wait_done(input int limit);
        int cyc;
        cyc = 0;
        while (!scurve_done) begin
            if (cyc == limit) begin
                $display("scurve_done did not rise within %0d cycles", limit);
                abort_run();
            end
            @(posedge clk);
            cyc++;
        end
    endtask

    // fall-through head sampled, then popped
    task automatic read_result(output count_t val);
        int cyc;
        cyc = 0;
        while (fifo_empty) begin
            if (cyc == 2 * step_cycles) begin
                $display("result FIFO stayed empty for %0d cycles", cyc);
                abort_run();
            end
            @(posedge clk);
            cyc++;
        end
        val = fifo_dout;
        fifo_rd_en <= 1'b1;
        @(posedge clk);
        fifo_rd_en <= 1'b0;
        @(posedge clk);  // pointers settle
    endtask

    task automatic check_sweep_frames(input int n);
        frame_t f;
        dac_t   code;
        if (frames.size() != n) begin
            $display("expected %0d sweep frames but saw %0d", n, frames.size());
            abort_run();
        end
        for (int i = 0; i < n; i++) begin
            f    = frames.pop_front();
            code = dac_t'(i);
            check_dac("frame dac0", f[frame_len-1 -: dac_w], code);
            check_dac("frame dac1", f[frame_len-1-dac_w -: dac_w], code);
            check_dac("frame dac2", f[frame_len-1-2*dac_w -: dac_w], code);
            check_frame("sweep frame", f, frame_of(code, code, code, chn));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        check_flag("select", select, 1'b0);
        check_flag("sr_ck", sr_ck, 1'b0);
        check_flag("sr_rstb", sr_rstb, 1'b1);
        check_flag("fifo_empty", fifo_empty, 1'b1);
        check_flag("scurve_done", scurve_done, 1'b0);
    endtask

    task automatic test_manual_load();
        int n;
        rnd = $random(seed);
        d0  = rnd[dac_w-1:0];
        rnd = $random(seed);
        d1  = rnd[dac_w-1:0];
        rnd = $random(seed);
        d2  = rnd[dac_w-1:0];
        rnd = $random(seed);
        chn = rnd[`SDH_CHN_W-1:0];
        send_cmd(dac_write_of(2'd0, d0));
        send_cmd(dac_write_of(2'd1, d1));
        send_cmd(dac_write_of(2'd2, d2));
        send_cmd(cmd_of(OP_SET_CHN, {{(12-`SDH_CHN_W){1'b0}}, chn}));
        send_cmd(cmd_of(OP_LOAD, 12'd0));
        n = 0;
        while (!select && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (n < 2 || n > 3) begin
            $display("select rose %0d cycles after LOAD instead of 2 to 3", n);
            abort_run();
        end
        wait_frames(1, 2 * step_cycles);
        check_frame("manual frame", frames.pop_front(), frame_of(d0, d1, d2, chn));
        repeat (8) @(posedge clk);  // handshake back to idle
    endtask

    task automatic test_dac1_rewrite();
        rnd = $random(seed);
        if (rnd[dac_w-1:0] == d1) d1 = ~d1;
        else d1 = rnd[dac_w-1:0];
        send_cmd(dac_write_of(2'd1, d1));
        send_cmd(cmd_of(OP_LOAD, 12'd0));
        wait_frames(1, 2 * step_cycles);
        check_frame("reload frame", frames.pop_front(), frame_of(d0, d1, d2, chn));
        repeat (8) @(posedge clk);
    endtask

    task automatic test_short_sweep();
        count_t v;
        send_cmd(cmd_of(OP_SET_WIN, 12'(win_cycles)));
        sweep_on = 1'b1;
        send_cmd(cmd_of(OP_SCURVE, 12'd7));
        wait_done(9 * step_cycles);
        sweep_on = 1'b0;
        check_sweep_frames(8);
        for (int i = 0; i < 8; i++) begin
            read_result(v);
            check_count("fifo_dout", v, count_t'(i % 5));
        end
        check_flag("fifo_empty", fifo_empty, 1'b1);
        fifo_rd_en <= 1'b1;  // pop with nothing stored
        @(posedge clk);
        fifo_rd_en <= 1'b0;
        @(posedge clk);
        check_flag("fifo_empty", fifo_empty, 1'b1);
    endtask

    // 21 results against a 16-deep FIFO, nothing read until it stalls
    task automatic test_sweep_backpressure();
        count_t v;
        sweep_on = 1'b1;
        send_cmd(cmd_of(OP_SCURVE, 12'd20));
        wait_frames(17, 18 * step_cycles);
        repeat (step_cycles) @(posedge clk);  // 17th count now stuck at push
        check_flag("scurve_done", scurve_done, 1'b0);
        check_flag("fifo_empty", fifo_empty, 1'b0);
        if (frames.size() != 17) begin
            $display("sweep moved on to another frame while the FIFO was full");
            abort_run();
        end
        for (int i = 0; i < 21; i++) begin
            read_result(v);
            check_count("fifo_dout", v, count_t'(i % 5));
        end
        wait_done(2 * step_cycles);
        sweep_on = 1'b0;
        check_sweep_frames(21);
        check_flag("fifo_empty", fifo_empty, 1'b1);
    endtask

    initial begin
        seed       = 8298;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_word   = '0;
        fifo_rd_en = 1'b0;
        sweep_on   = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_manual_load();
        test_dac1_rewrite();
        test_short_sweep();
        test_sweep_backpressure();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/sdhcal_pkg.sv
src/usb_cmd_decoder.sv
src/sc_serializer.sv
src/trigger_counter.sv
src/result_fifo.sv
src/scurve_sequencer.sv
src/sdhcal_top.sv
dv/sdhcal_props.sv
dv/tb_sdhcal.sv

//--- Makefile
TOP := tb_sdhcal

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): sources.f $(wildcard src/*.sv src/*.svh dv/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
